//--- hw/pc_coef.svh
`ifndef PC_COEF_SVH
`define PC_COEF_SVH

// In-phase part of the chirp, index 0 pairs with the newest sample
localparam logic signed [COEF_W-1:0] COEF_I [TAPS] = '{
	   -1,  2046,   128, -2027,  -510,  1891,  1096, -1471, -1729,   601,
	 2047,   663, -1578, -1810,   128,  1891,  1577,  -352, -1904, -1675,
	   -1,  1636,  1982,   900,  -754, -1892, -1904,  -901,   509,  1636,
	 2047,  1674,   753,  -352, -1305, -1892, -2043, -1810, -1305,  -664,
	   -1,   601,  1096,  1470,  1728,  1891,  1982,  2026,  2042,  2046,
	 2047,  2046,  2042,  2026,  1982,  1891,  1728,  1470,  1096,   601,
	   -1,  -664, -1305, -1810, -2043, -1892, -1305,  -352,   753,  1674,
	 2047,  1636,   509,  -901, -1904, -1892,  -754,   900,  1982,  1636,
	   -1, -1675, -1904,  -352,  1577,  1891,   128, -1810, -1578,   663,
	 2047,   601, -1729, -1471,  1096,  1891,  -510, -2027,   128,  2046
};

// Quadrature part of the chirp
localparam logic signed [COEF_W-1:0] COEF_Q [TAPS] = '{
	 2047,    32, -2043,  -289,  1982,   783, -1729, -1425,  1096,  1956,
	    0, -1937, -1305,   957,  2042,   783, -1305, -2017,  -754,  1177,
	 2047,  1229,  -510, -1839, -1904,  -784,   753,  1838,  1982,  1229,
	    0, -1178, -1904, -2017, -1578,  -784,   128,   957,  1577,  1936,
	 2047,  1956,  1728,  1424,  1096,   783,   509,   288,   128,    32,
	    0,    32,   128,   288,   509,   783,  1096,  1424,  1728,  1956,
	 2047,  1936,  1577,   957,   128,  -784, -1578, -2017, -1904, -1178,
	    0,  1229,  1982,  1838,   753,  -784, -1904, -1839,  -510,  1229,
	 2047,  1177,  -754, -2017, -1305,   783,  2042,   957, -1305, -1937,
	    0,  1956,  1096, -1425, -1729,   783,  1982,  -289, -2043,    32
};

`endif

//--- hw/pc_correlator.sv
`timescale 1ns/100ps

module pc_correlator
	import pc_pkg::*;
#(
	parameter int TAPS = pc_pkg::TAPS
)
(
	input  logic    clk,
	input  logic    rst,
	input  sample_t taps_i [TAPS],
	input  sample_t taps_q [TAPS],
	output acc_t    corr_i,
	output acc_t    corr_q
);

	// Full product of one sample and one coefficient
	localparam int PROD_W = SAMPLE_W + COEF_W;

	acc_t term_i [TAPS];
	acc_t term_q [TAPS];
	acc_t sum_i;
	acc_t sum_q;

	// --------------------
	// Per-tap products
	// --------------------

	// Sample times the conjugated replica
	// (I + jQ)(hI - j hQ) = (I hI + Q hQ) + j(Q hI - I hQ)
	for (genvar k = 0; k < TAPS; k++)
	begin : g_tap
		logic signed [PROD_W-1:0] i_hi;
		logic signed [PROD_W-1:0] q_hq;
		logic signed [PROD_W-1:0] q_hi;
		logic signed [PROD_W-1:0] i_hq;

		assign i_hi = taps_i[k] * COEF_I[k];
		assign q_hq = taps_q[k] * COEF_Q[k];
		assign q_hi = taps_q[k] * COEF_I[k];
		assign i_hq = taps_i[k] * COEF_Q[k];

		assign term_i[k] = acc_t'(i_hi) + acc_t'(q_hq);
		assign term_q[k] = acc_t'(q_hi) - acc_t'(i_hq);
	end

	// --------------------
	// Accumulation
	// --------------------

	// Wraps at ACC_W bits
	always_comb
	begin
		sum_i = '0;
		sum_q = '0;
		for (int k = 0; k < TAPS; k++)
		begin
			sum_i = sum_i + term_i[k];
			sum_q = sum_q + term_q[k];
		end
	end

	// --------------------
	// Output register
	// --------------------

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			corr_i <= '0;
			corr_q <= '0;
		end
		else
		begin
			corr_i <= sum_i;
			corr_q <= sum_q;
		end
	end

endmodule

//--- hw/pc_delay_line.sv
`timescale 1ns/100ps

module pc_delay_line
	import pc_pkg::*;
#(
	parameter int  DEPTH     = TAPS,
	parameter type payload_t = sample_t
)
(
	input  logic     clk,
	input  logic     rst,
	input  payload_t din,
	output payload_t taps [DEPTH]
);

	// --------------------
	// Shift register
	// --------------------

	// Tap 0 takes the new sample, everything else moves one place up
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			for (int k = 0; k < DEPTH; k++)
			begin
				taps[k] <= '0;
			end
		end
		else
		begin
			taps[0] <= din;
			for (int k = 1; k < DEPTH; k++)
			begin
				taps[k] <= taps[k-1];
			end
		end
	end

endmodule

//--- hw/pc_pkg.sv
package pc_pkg;

	// --------------------
	// Widths and length
	// --------------------

	// One I or Q input sample
	localparam int SAMPLE_W = 12;

	// One chirp coefficient
	localparam int COEF_W = 12;

	// Filter length, newest sample is tap 0
	localparam int TAPS = 100;

	// Correlator result, truncated to three sample widths
	localparam int ACC_W = 3 * SAMPLE_W;

	// Squared magnitude with one bit of headroom
	localparam int POW_W = 6 * SAMPLE_W + 1;

	// --------------------
	// Data types
	// --------------------

	typedef logic signed [SAMPLE_W-1:0] sample_t;

	typedef logic signed [ACC_W-1:0] acc_t;

	typedef logic [POW_W-1:0] pow_t;

	// --------------------
	// Chirp replica
	// --------------------

	`include "pc_coef.svh"

endpackage

//--- hw/pc_power.sv
`timescale 1ns/100ps

module pc_power
	import pc_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  acc_t corr_i,
	input  acc_t corr_q,
	output pow_t power
);

	// Both squares are non-negative
	logic signed [2*ACC_W-1:0] sq_i;
	logic signed [2*ACC_W-1:0] sq_q;

	assign sq_i = corr_i * corr_i;
	assign sq_q = corr_q * corr_q;

	// --------------------
	// Squared magnitude
	// --------------------

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			power <= '0;
		end
		else
		begin
			// Spare top bit holds the carry of the sum
			power <= {1'b0, sq_i} + {1'b0, sq_q};
		end
	end

endmodule

//--- hw/pc_top.sv
`timescale 1ns/100ps

module pc_top
	import pc_pkg::*;
#(
	parameter int TAPS = pc_pkg::TAPS
)
(
	input  logic    clk,
	input  logic    rst,
	input  sample_t sample_i,
	input  sample_t sample_q,
	output acc_t    corr_i,
	output acc_t    corr_q,
	output pow_t    power
);

	sample_t taps_i [TAPS];
	sample_t taps_q [TAPS];

	// --------------------
	// Sample windows
	// --------------------

	pc_delay_line #(
		.DEPTH     (TAPS),
		.payload_t (sample_t)
	) u_delay_i (
		.clk  (clk),
		.rst  (rst),
		.din  (sample_i),
		.taps (taps_i)
	);

	pc_delay_line #(
		.DEPTH     (TAPS),
		.payload_t (sample_t)
	) u_delay_q (
		.clk  (clk),
		.rst  (rst),
		.din  (sample_q),
		.taps (taps_q)
	);

	// --------------------
	// Matched filter
	// --------------------

	pc_correlator #(
		.TAPS (TAPS)
	) u_correlator (
		.clk    (clk),
		.rst    (rst),
		.taps_i (taps_i),
		.taps_q (taps_q),
		.corr_i (corr_i),
		.corr_q (corr_q)
	);

	// One cycle behind the correlator outputs
	pc_power u_power (
		.clk    (clk),
		.rst    (rst),
		.corr_i (corr_i),
		.corr_q (corr_q),
		.power  (power)
	);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the matched filter testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

if ! verilator --binary --timing -Wno-fatal --top-module tb_pc -f tb.f -o Vtb_pc \
	> "$BUILD_LOG" 2>&1; then
	cat "$BUILD_LOG"
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_pc > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "STATUS: FAIL" "$SIM_LOG"; then
	exit 1
fi

if [ "$sim_status" -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if ! grep -q "STATUS: PASS" "$SIM_LOG"; then
	echo "Simulation ended without a result"
	exit 1
fi

exit 0

//--- tb.f
+incdir+hw
hw/pc_pkg.sv
hw/pc_delay_line.sv
hw/pc_correlator.sv
hw/pc_power.sv
hw/pc_top.sv
test/tb_clock_gen.sv
test/tb_pc.sv

//--- test/pc_testdata.txt
# rst sample_i sample_q corr_i corr_q power
# expected values are for the window that holds this line's sample as tap 0
1 0 0 0 0 0
1 0 0 0 0 0
1 1 0 -1 -2047 4190210
1 0 0 2046 -32 4187140
1 0 0 128 2043 4190233
1 0 0 -2027 289 4192250
1 0 0 -510 -1982 4188424
1 0 0 1891 -783 4188970
1 0 0 1096 1729 4190657
1 0 0 -1471 1425 4194466
1 0 0 -1729 -1096 4190657
1 0 0 601 -1956 4187137
1 0 0 2047 0 4190209
1 0 0 663 1937 4191538
1 0 0 -1578 1305 4193109
1 0 0 -1810 -957 4191949
1 0 0 128 -2042 4186148
1 0 0 1891 -783 4188970
1 0 0 1577 1305 4189954
1 0 0 -352 2017 4192193
1 0 0 -1904 754 4193732
1 0 0 -1675 -1177 4190954
1 0 0 -1 -2047 4190210
1 0 0 1636 -1229 4186937
1 0 0 1982 510 4188424
1 0 0 900 1839 4191921
1 0 0 -754 1904 4193732
1 0 0 -1892 784 4194320
1 0 0 -1904 -753 4192225
1 0 0 -901 -1838 4190045
1 0 0 509 -1982 4187405
1 0 0 1636 -1229 4186937
1 0 0 2047 0 4190209
1 0 0 1674 1178 4189960
1 0 0 753 1904 4192225
1 0 0 -352 2017 4192193
1 0 0 -1305 1578 4193109
1 0 0 -1892 784 4194320
1 0 0 -2043 -128 4190233
1 0 0 -1810 -957 4191949
1 0 0 -1305 -1577 4189954
1 0 0 -664 -1936 4188992
1 -1 0 0 0 0
1 0 0 0 0 0
0 7 -7 0 0 0
1 0 -1 -2047 1 4190210
1 0 0 -32 -2046 4187140
1 0 0 2043 -128 4190233
1 0 0 289 2027 4192250
1 0 0 -1982 510 4188424
1 0 0 -783 -1891 4188970
1 0 0 1729 -1096 4190657
1 0 0 1425 1471 4194466
1 0 0 -1096 1729 4190657
1 0 0 -1956 -601 4187137
1 0 0 0 -2047 4190209
1 0 0 1937 -663 4191538
1 0 0 1305 1578 4193109
1 0 0 -957 1810 4191949
1 0 0 -2042 -128 4186148
1 0 0 -783 -1891 4188970
1 0 0 1305 -1577 4189954
1 0 0 2017 352 4192193
1 0 0 754 1904 4193732
1 0 0 -1177 1675 4190954
1 0 0 -2047 1 4190210
1 0 0 -1229 -1636 4186937
1 0 0 510 -1982 4188424
1 0 0 1839 -900 4191921
1 0 0 1904 754 4193732
1 0 0 784 1892 4194320
1 0 0 -753 1904 4192225
1 0 0 -1838 901 4190045
1 0 0 -1982 -509 4187405
1 0 0 -1229 -1636 4186937
1 0 0 0 -2047 4190209
1 0 0 1178 -1674 4189960
1 0 0 1904 -753 4192225
1 0 0 2017 352 4192193
1 0 0 1578 1305 4193109
1 0 0 784 1892 4194320
1 0 0 -128 2043 4190233
1 0 0 -957 1810 4191949
1 0 0 -1577 1305 4189954
1 0 0 -1936 664 4188992
1 0 1 0 0 0
1 0 0 0 0 0
0 0 0 0 0 0
1 -2048 0 2048 4192256 17575014563840
1 0 2047 1 63489 4030853122
1 0 0 -196640 4098 38684083204

//--- test/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter int RESET_CYCLES = 5
)
(
	output logic clk,
	output logic rst
);

	// 10 ns period
	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial
	begin
		rst = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b1;
	end

endmodule

//--- test/tb_pc.sv
`timescale 1ns/100ps

module tb_pc
	import pc_pkg::*;
();

	localparam int    MAX_LINES   = 256;
	localparam int    RESET_LIMIT = 20;
	localparam string DATA_FILE   = "test/pc_testdata.txt";

	logic    clk;
	logic    rst_gen;
	logic    line_rst;
	logic    dut_rst;
	sample_t sample_i;
	sample_t sample_q;
	acc_t    corr_i;
	acc_t    corr_q;
	pow_t    power;

	// Expected results, indexed by data line
	acc_t exp_ci [MAX_LINES];
	acc_t exp_cq [MAX_LINES];
	pow_t exp_pow [MAX_LINES];

	int fd;
	int n_lines;

	// Power-on reset and the reset column of the data file
	assign dut_rst = rst_gen & line_rst;

	tb_clock_gen #(
		.RESET_CYCLES (5)
	) u_clock_gen (
		.clk (clk),
		.rst (rst_gen)
	);

	pc_top #(
		.TAPS (TAPS)
	) uut (
		.clk      (clk),
		.rst      (dut_rst),
		.sample_i (sample_i),
		.sample_q (sample_q),
		.corr_i   (corr_i),
		.corr_q   (corr_q),
		.power    (power)
	);

	// --------------------
	// Helpers
	// --------------------

	task automatic compare_value(input string name, input logic signed [127:0] expected,
		input logic signed [127:0] actual);
		if (expected !== actual)
		begin
			$display("** Error: %s expected %0d actual %0d", name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1);
		end
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	// Next data line, comment and blank lines skipped
	task automatic read_line(output bit got, output logic r, output sample_t si,
		output sample_t sq, output acc_t ci, output acc_t cq, output pow_t p);
		string  text;
		int     fields;
		int     v_rst;
		int     v_si;
		int     v_sq;
		longint v_ci;
		longint v_cq;
		longint v_p;
		bit     done;
		got = 0;
		done = 0;
		r = 1'b1;
		si = '0;
		sq = '0;
		ci = '0;
		cq = '0;
		p = '0;
		while (!done)
		begin
			if ($fgets(text, fd) == 0)
			begin
				done = 1;
			end
			else if (text.len() > 1 && text.getc(0) != "#")
			begin
				fields = $sscanf(text, "%d %d %d %d %d %d", v_rst, v_si, v_sq, v_ci, v_cq, v_p);
				if (fields != 6)
				begin
					abort_run($sformatf("Malformed line in the test data file: %s", text));
				end
				r = v_rst[0];
				si = sample_t'(v_si);
				sq = sample_t'(v_sq);
				ci = acc_t'(v_ci);
				cq = acc_t'(v_cq);
				p = pow_t'(v_p);
				got = 1;
				done = 1;
			end
		end
	endtask

	// Correlator runs two cycles behind the drive, power three
	task automatic check_outputs(input int cycle);
		if (cycle >= 2 && cycle - 2 < n_lines)
		begin
			compare_value($sformatf("line %0d corr_i", cycle - 2), exp_ci[cycle-2], corr_i);
			compare_value($sformatf("line %0d corr_q", cycle - 2), exp_cq[cycle-2], corr_q);
		end
		if (cycle >= 3 && cycle - 3 < n_lines)
		begin
			compare_value($sformatf("line %0d power", cycle - 3), exp_pow[cycle-3], power);
		end
	endtask

	// --------------------
	// Stimulus
	// --------------------

	initial
	begin
		bit      got;
		bit      released;
		logic    r;
		sample_t si;
		sample_t sq;
		acc_t    ci;
		acc_t    cq;
		pow_t    p;
		int      cycle;
		int      waited;

		line_rst = 1'b1;
		sample_i = '0;
		sample_q = '0;
		n_lines = 0;

		fd = $fopen(DATA_FILE, "r");
		if (fd == 0)
		begin
			abort_run($sformatf("Could not open the test data file %s", DATA_FILE));
		end

		// Outputs must sit at zero while reset is held
		waited = 0;
		released = 0;
		while (!released)
		begin
			@(posedge clk);
			@(negedge clk);
			waited++;
			compare_value("reset corr_i", 0, corr_i);
			compare_value("reset corr_q", 0, corr_q);
			compare_value("reset power", 0, power);
			if (rst_gen)
			begin
				released = 1;
			end
			else if (waited > RESET_LIMIT)
			begin
				abort_run("Reset was not released in time");
			end
		end

		cycle = 0;
		read_line(got, r, si, sq, ci, cq, p);
		while (got)
		begin
			if (cycle >= MAX_LINES)
			begin
				abort_run("The test data file has more lines than the testbench can hold");
			end
			@(posedge clk);
			line_rst <= r;
			sample_i <= si;
			sample_q <= sq;
			exp_ci[cycle] = ci;
			exp_cq[cycle] = cq;
			exp_pow[cycle] = p;
			n_lines = cycle + 1;
			@(negedge clk);
			check_outputs(cycle);
			cycle++;
			read_line(got, r, si, sq, ci, cq, p);
		end

		// Let the last lines reach the outputs
		for (int k = 0; k < 3; k++)
		begin
			@(posedge clk);
			line_rst <= 1'b1;
			sample_i <= '0;
			sample_q <= '0;
			@(negedge clk);
			check_outputs(cycle);
			cycle++;
		end

		$fclose(fd);
		$display("STATUS: PASS");
		$finish;
	end

endmodule
